// File: hdl/periph_map_pkg.sv
// Address map of the peripheral subsystem. Windows are 16 bytes and decoded on
// paddr[11:4]; only word-aligned register offsets are defined.
`default_nettype none

package periph_map_pkg;

    // Bus widths
    localparam int AddrWidth = 12;
    localparam int DataWidth = 32;

    // --------------------
    // Slave windows
    // --------------------
    localparam logic [AddrWidth-1:0] TimerBase0 = 12'h000;
    localparam logic [AddrWidth-1:0] TimerBase1 = 12'h010;
    localparam logic [AddrWidth-1:0] IrqBase    = 12'h100;

    // Timer registers
    localparam logic [3:0] TimerCountOff = 4'h0;
    localparam logic [3:0] TimerCtrlOff  = 4'h4;
    localparam logic [3:0] TimerCmpOff   = 4'h8;
    localparam logic [3:0] TimerStatOff  = 4'hC;

    // Router registers, one enable mask per target
    localparam logic [3:0] IrqPendOff = 4'h0;
    localparam logic [3:0] IrqEnOff0  = 4'h4;
    localparam logic [3:0] IrqEnOff1  = 4'h8;

    localparam logic [DataWidth-1:0] ErrorWord = 32'hdeadbeef; // absent slave

    // Timer slots must keep the encodings 0 and 1
    typedef enum logic [1:0] {
        SlotTimer0 = 2'd0,
        SlotTimer1 = 2'd1,
        SlotIrq    = 2'd2,
        SlotNone   = 2'd3
    } SlotSel;

endpackage

`default_nettype wire

// File: hdl/periph_bus_pkg.sv
// APB port and internal register bus types. One transfer in flight at a time.
`default_nettype none

package periph_bus_pkg;

    // --------------------
    // APB slave port
    // --------------------
    typedef struct packed {
        logic                                 psel;
        logic                                 penable;
        logic                                 pwrite;
        logic [periph_map_pkg::AddrWidth-1:0] paddr;
        logic [periph_map_pkg::DataWidth-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [periph_map_pkg::DataWidth-1:0] prdata;
        logic                                 pready;
        logic                                 pslverr;
    } apb_rsp_t;

    // Shared register request, valid is a one-cycle strobe
    typedef struct packed {
        logic                                 valid;
        logic                                 write;
        logic [3:0]                           offset; // byte offset in window
        logic [periph_map_pkg::DataWidth-1:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire

// File: hdl/apb_access_fsm.sv
// Fixed-latency APB slave: setup plus two access cycles, no extra wait states.
// Timer slots 0 and 1 map to slot_valid_o bits 0 and 1, the router to bit NumTimers.
`timescale 1ns/100ps
`default_nettype none

module apb_access_fsm #(
    parameter int NumTimers = 2
) (
    input  logic                                                 clk_i,
    input  logic                                                 reset_i,
    input  periph_bus_pkg::apb_req_t                             apb_req_i,
    output periph_bus_pkg::apb_rsp_t                             apb_rsp_o,
    output periph_bus_pkg::reg_req_t                             reg_req_o,
    output logic [NumTimers:0]                                   slot_valid_o,
    input  logic [NumTimers-1:0][periph_map_pkg::DataWidth-1:0]  timer_rdata_i,
    input  logic [periph_map_pkg::DataWidth-1:0]                 irq_rdata_i
);

    localparam int AW = periph_map_pkg::AddrWidth;

    typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_e;

    state_e                               state_q;
    periph_map_pkg::SlotSel               slot_q;
    logic [1:0]                           slot_idx;
    logic                                 setup;
    logic                                 err_q;
    logic                                 write_q;
    logic [3:0]                           offset_q;
    logic [periph_map_pkg::DataWidth-1:0] wdata_q;
    logic [periph_map_pkg::DataWidth-1:0] rdata_q;
    logic [periph_map_pkg::DataWidth-1:0] rdata_mux;

    function automatic periph_map_pkg::SlotSel decode_slot(input logic [AW-1:0] addr);
        logic [AW-5:0] win;
        win = addr[AW-1:4];
        if (win == periph_map_pkg::TimerBase0[AW-1:4]) return periph_map_pkg::SlotTimer0;
        if (NumTimers > 1 && win == periph_map_pkg::TimerBase1[AW-1:4])
            return periph_map_pkg::SlotTimer1;
        if (win == periph_map_pkg::IrqBase[AW-1:4]) return periph_map_pkg::SlotIrq;
        return periph_map_pkg::SlotNone;
    endfunction

    assign setup    = (state_q == IDLE) && apb_req_i.psel && !apb_req_i.penable;
    assign slot_idx = slot_q;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            slot_q  <= periph_map_pkg::SlotNone;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (setup) begin
                        state_q <= ACCESS;
                        slot_q  <= decode_slot(apb_req_i.paddr);
                    end
                end
                ACCESS: begin
                    state_q <= RESPOND;
                    err_q   <= (slot_q == periph_map_pkg::SlotNone);
                end
                default: state_q <= IDLE; // RESPOND lasts one cycle
            endcase
        end
    end

    // Request payload captured at setup, read data at the strobe edge
    always_ff @(posedge clk_i) begin
        if (setup) begin
            write_q  <= apb_req_i.pwrite;
            offset_q <= apb_req_i.paddr[3:0];
            wdata_q  <= apb_req_i.pwdata;
        end
        if (state_q == ACCESS) rdata_q <= rdata_mux;
    end

    always_comb begin
        case (slot_q)
            periph_map_pkg::SlotTimer0,
            periph_map_pkg::SlotTimer1: rdata_mux = timer_rdata_i[slot_idx[0]];
            periph_map_pkg::SlotIrq:    rdata_mux = irq_rdata_i;
            default:                    rdata_mux = periph_map_pkg::ErrorWord;
        endcase
    end

    always_comb begin
        slot_valid_o = '0;
        if (state_q == ACCESS) begin
            case (slot_q)
                periph_map_pkg::SlotTimer0,
                periph_map_pkg::SlotTimer1: slot_valid_o[slot_idx] = 1'b1;
                periph_map_pkg::SlotIrq:    slot_valid_o[NumTimers] = 1'b1;
                default: ;                  // unmapped, nothing written
            endcase
        end
    end

    always_comb begin
        reg_req_o.valid  = (state_q == ACCESS);
        reg_req_o.write  = write_q;
        reg_req_o.offset = offset_q;
        reg_req_o.wdata  = wdata_q;
    end

    assign apb_rsp_o.prdata  = rdata_q;
    assign apb_rsp_o.pready  = (state_q == RESPOND);
    assign apb_rsp_o.pslverr = (state_q == RESPOND) && err_q;

    // --------------------
    // Checks
    // --------------------
    a_pready_single: assert property (@(posedge clk_i) disable iff (reset_i)
        apb_rsp_o.pready |=> !apb_rsp_o.pready);

    a_slot_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(slot_valid_o));

endmodule

`default_nettype wire

// File: hdl/periph_timer.sv
// Compare-match timer. Count wraps to 0 once it reaches compare; the match flag
// is sticky until status is written. Count bits above CountWidth read as 0.
`timescale 1ns/100ps
`default_nettype none

module periph_timer #(
    parameter int CountWidth = periph_map_pkg::DataWidth
) (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 valid_i,
    input  periph_bus_pkg::reg_req_t             reg_req_i,
    output logic [periph_map_pkg::DataWidth-1:0] rdata_o,
    output logic                                 irq_o
);

    logic [CountWidth-1:0] count_q;
    logic [CountWidth-1:0] cmp_q;
    logic                  enable_q;
    logic                  flag_q;
    logic                  wr_en;
    logic                  match;

    assign wr_en = valid_i && reg_req_i.valid && reg_req_i.write;
    assign match = enable_q && (count_q >= cmp_q); // also catches a lowered compare

    // --------------------
    // Counter and flag
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q  <= '0;
            enable_q <= 1'b0;
            flag_q   <= 1'b0;
        end else begin
            if (match) begin
                count_q <= '0;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en && reg_req_i.offset == periph_map_pkg::TimerCountOff)
                count_q <= reg_req_i.wdata[CountWidth-1:0]; // software load wins
            if (wr_en && reg_req_i.offset == periph_map_pkg::TimerCtrlOff)
                enable_q <= reg_req_i.wdata[0];
            if (wr_en && reg_req_i.offset == periph_map_pkg::TimerStatOff)
                flag_q <= 1'b0;
            if (match) flag_q <= 1'b1; // a new match beats the clear
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && reg_req_i.offset == periph_map_pkg::TimerCmpOff)
            cmp_q <= reg_req_i.wdata[CountWidth-1:0];
    end

    // Read mux
    always_comb begin
        rdata_o = '0;
        case (reg_req_i.offset)
            periph_map_pkg::TimerCountOff: rdata_o[CountWidth-1:0] = count_q;
            periph_map_pkg::TimerCtrlOff:  rdata_o[0] = enable_q;
            periph_map_pkg::TimerCmpOff:   rdata_o[CountWidth-1:0] = cmp_q;
            periph_map_pkg::TimerStatOff:  rdata_o[0] = flag_q;
            default: ;
        endcase
    end

    assign irq_o = flag_q;

    // Bound holds except right after software touched count or compare
    a_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        enable_q && cmp_q != '0 && !$past(wr_en) |-> count_q <= cmp_q);

endmodule

`default_nettype wire

// File: hdl/irq_router.sv
// Level-only interrupt router with one enable mask per target, no priorities.
// NumSources up to DataWidth; enable mask offsets follow the IrqEnOff0/1 stride.
`timescale 1ns/100ps
`default_nettype none

module irq_router #(
    parameter int NumSources = 4,
    parameter int NumTargets = 2
) (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 valid_i,
    input  periph_bus_pkg::reg_req_t             reg_req_i,
    output logic [periph_map_pkg::DataWidth-1:0] rdata_o,
    input  logic [NumSources-1:0]                src_i,
    output logic [NumTargets-1:0]                irq_o
);

    localparam logic [3:0] EnStride = periph_map_pkg::IrqEnOff1 - periph_map_pkg::IrqEnOff0;

    logic [NumTargets-1:0][NumSources-1:0] en_q;
    logic [NumTargets-1:0]                 irq_q;
    logic                                  wr_en;

    function automatic logic [3:0] en_off(input int t);
        return periph_map_pkg::IrqEnOff0 + 4'(t) * EnStride;
    endfunction

    assign wr_en = valid_i && reg_req_i.valid && reg_req_i.write;

    // --------------------
    // Masks and targets
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            en_q  <= '0;
            irq_q <= '0;
        end else begin
            for (int t = 0; t < NumTargets; t++) begin
                if (wr_en && reg_req_i.offset == en_off(t))
                    en_q[t] <= reg_req_i.wdata[NumSources-1:0];
                irq_q[t] <= |(src_i & en_q[t]);
            end
        end
    end

    // Pending is the live source level, not latched
    always_comb begin
        rdata_o = '0;
        if (reg_req_i.offset == periph_map_pkg::IrqPendOff)
            rdata_o[NumSources-1:0] = src_i;
        for (int t = 0; t < NumTargets; t++) begin
            if (reg_req_i.offset == en_off(t))
                rdata_o[NumSources-1:0] = en_q[t];
        end
    end

    assign irq_o = irq_q;

    a_irq_reset: assert property (@(posedge clk_i) reset_i |=> irq_o == '0);

endmodule

`default_nettype wire

// File: hdl/periph_top.sv
// Peripheral subsystem top. Router sources are the timer flags first, then the
// external level inputs.
`timescale 1ns/100ps
`default_nettype none

module periph_top #(
    parameter int NumTimers  = 2,
    parameter int NumExtIrq  = 2,
    parameter int NumTargets = 2
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  periph_bus_pkg::apb_req_t apb_req_i,
    output periph_bus_pkg::apb_rsp_t apb_rsp_o,
    input  logic [NumExtIrq-1:0]     irq_ext_i,
    output logic [NumTargets-1:0]    irq_o
);

    localparam int NumSources = NumTimers + NumExtIrq;

    periph_bus_pkg::reg_req_t                             reg_req;
    logic [NumTimers:0]                                   slot_valid;
    logic [NumTimers-1:0][periph_map_pkg::DataWidth-1:0]  timer_rdata;
    logic [periph_map_pkg::DataWidth-1:0]                 irq_rdata;
    logic [NumTimers-1:0]                                 timer_irq;

    // --------------------
    // Bus front end
    // --------------------
    apb_access_fsm #(
        .NumTimers ( NumTimers )
    ) i_apb_access_fsm (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .apb_req_i     ( apb_req_i   ),
        .apb_rsp_o     ( apb_rsp_o   ),
        .reg_req_o     ( reg_req     ),
        .slot_valid_o  ( slot_valid  ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   )
    );

    // Timers
    for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
        periph_timer i_periph_timer (
            .clk_i     ( clk_i          ),
            .reset_i   ( reset_i        ),
            .valid_i   ( slot_valid[i]  ),
            .reg_req_i ( reg_req        ),
            .rdata_o   ( timer_rdata[i] ),
            .irq_o     ( timer_irq[i]   )
        );
    end

    // --------------------
    // Interrupts
    // --------------------
    irq_router #(
        .NumSources ( NumSources ),
        .NumTargets ( NumTargets )
    ) i_irq_router (
        .clk_i     ( clk_i                   ),
        .reset_i   ( reset_i                 ),
        .valid_i   ( slot_valid[NumTimers]   ),
        .reg_req_i ( reg_req                 ),
        .rdata_o   ( irq_rdata               ),
        .src_i     ( {irq_ext_i, timer_irq}  ),
        .irq_o     ( irq_o                   )
    );

endmodule

`default_nettype wire

// File: dv/tb_periph_top.sv
// Testbench for periph_top with two timers, two external lines and two targets.
// Every APB transfer is expected to take one setup and two access cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_periph_top;

    localparam int          PollTries = 40;
    localparam logic [31:0] SrcMask   = 32'h0000_000f; // four router sources
    localparam logic [31:0] ErrWord   = 32'hdeadbeef;

    localparam logic [11:0] T0Ctrl  = 12'h004;
    localparam logic [11:0] T0Cmp   = 12'h008;
    localparam logic [11:0] T0Stat  = 12'h00C;
    localparam logic [11:0] T1Ctrl  = 12'h014;
    localparam logic [11:0] T1Cmp   = 12'h018;
    localparam logic [11:0] T1Stat  = 12'h01C;
    localparam logic [11:0] IrqPend = 12'h100;
    localparam logic [11:0] IrqEn0  = 12'h104;
    localparam logic [11:0] IrqEn1  = 12'h108;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_IDLE, OP_EXT, OP_IRQ} op_e;

    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] wdata;  // write data, wait length or irq_ext value
        logic [31:0] exp;
        logic        exp_err;
    } entry_t;

    logic                     clk_i;
    logic                     reset_i;
    periph_bus_pkg::apb_req_t apb_req;
    periph_bus_pkg::apb_rsp_t apb_rsp;
    logic [1:0]               irq_ext;
    logic [1:0]               irq;

    entry_t      tbl[$];
    logic [31:0] lfsr_q;
    int          errors;
    int          failed_tests;
    int          watchdog_cycles;
    logic        table_built;

    periph_top #(
        .NumTimers  ( 2 ),
        .NumExtIrq  ( 2 ),
        .NumTargets ( 2 )
    ) DUT (
        .clk_i     ( clk_i   ),
        .reset_i   ( reset_i ),
        .apb_req_i ( apb_req ),
        .apb_rsp_o ( apb_rsp ),
        .irq_ext_i ( irq_ext ),
        .irq_o     ( irq     )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Galois LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Target is high when any pending source is enabled
    function automatic logic [1:0] route(input logic [3:0] pend, input logic [3:0] m0,
                                         input logic [3:0] m1);
        return {|(pend & m1), |(pend & m0)};
    endfunction

    function automatic void add_entry(input op_e op, input logic [11:0] addr,
                                      input logic [31:0] wdata, input logic [31:0] exp,
                                      input logic exp_err);
        tbl.push_back('{op, addr, wdata, exp, exp_err});
    endfunction

    function automatic void add_mask_case(input logic [3:0] m0, input logic [3:0] m1);
        add_entry(OP_WR, IrqEn0, {28'h0, m0}, '0, 1'b0);
        add_entry(OP_WR, IrqEn1, {28'h0, m1}, '0, 1'b0);
        add_entry(OP_IRQ, 12'h000, '0, {30'h0, route(4'b1000, m0, m1)}, 1'b0);
    endfunction

    function automatic string op_name(input op_e op);
        case (op)
            OP_WR:   return "write";
            OP_RD:   return "read";
            OP_POLL: return "poll";
            OP_IDLE: return "idle";
            OP_EXT:  return "ext";
            default: return "irq";
        endcase
    endfunction

    // --------------------
    // Stimulus table
    // --------------------
    function automatic void build_table();
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] m0;
        logic [31:0] m1;
        logic [31:0] r0;
        logic [31:0] r1;
        add_entry(OP_IRQ, 12'h000, '0, '0, 1'b0);   // reset values
        add_entry(OP_RD, T0Ctrl, '0, '0, 1'b0);
        add_entry(OP_RD, T0Stat, '0, '0, 1'b0);
        add_entry(OP_RD, T1Ctrl, '0, '0, 1'b0);
        add_entry(OP_RD, T1Stat, '0, '0, 1'b0);
        add_entry(OP_RD, IrqEn0, '0, '0, 1'b0);
        add_entry(OP_RD, IrqEn1, '0, '0, 1'b0);
        c0 = rand_bits(32);
        c1 = rand_bits(32);
        m0 = rand_bits(32);
        m1 = rand_bits(32);
        add_entry(OP_WR, T0Cmp, c0, '0, 1'b0);
        add_entry(OP_WR, T1Cmp, c1, '0, 1'b0);
        add_entry(OP_WR, IrqEn0, m0, '0, 1'b0);
        add_entry(OP_WR, IrqEn1, m1, '0, 1'b0);
        add_entry(OP_RD, T0Cmp, '0, c0, 1'b0);
        add_entry(OP_RD, T1Cmp, '0, c1, 1'b0);
        add_entry(OP_RD, IrqEn0, '0, m0 & SrcMask, 1'b0);
        add_entry(OP_RD, IrqEn1, '0, m1 & SrcMask, 1'b0);
        // Offset 8 would hit compare or mask 1 if the decode leaked
        add_entry(OP_WR, 12'h028, rand_bits(32), '0, 1'b1);
        add_entry(OP_WR, 12'h208, rand_bits(32), '0, 1'b1);
        add_entry(OP_RD, 12'h020, '0, ErrWord, 1'b1);
        add_entry(OP_RD, 12'h200, '0, ErrWord, 1'b1);
        add_entry(OP_RD, T0Cmp, '0, c0, 1'b0);
        add_entry(OP_RD, T1Cmp, '0, c1, 1'b0);
        add_entry(OP_RD, IrqEn1, '0, m1 & SrcMask, 1'b0);
        add_entry(OP_WR, IrqEn0, 32'h1, '0, 1'b0);  // timer match
        add_entry(OP_WR, IrqEn1, 32'h0, '0, 1'b0);
        add_entry(OP_WR, T0Cmp, 32'd20, '0, 1'b0);
        add_entry(OP_WR, T0Ctrl, 32'h1, '0, 1'b0);
        add_entry(OP_IDLE, 12'h000, 32'd60 + rand_bits(5), '0, 1'b0);
        add_entry(OP_POLL, T0Stat, '0, 32'h1, 1'b0);
        add_entry(OP_RD, IrqPend, '0, 32'h1, 1'b0);
        add_entry(OP_IRQ, 12'h000, '0, 32'h1, 1'b0);
        add_entry(OP_WR, T0Ctrl, 32'h0, '0, 1'b0);  // flag clear
        add_entry(OP_WR, T0Stat, rand_bits(32), '0, 1'b0);
        add_entry(OP_IRQ, 12'h000, '0, '0, 1'b0);
        add_entry(OP_RD, T0Stat, '0, '0, 1'b0);
        add_entry(OP_RD, IrqPend, '0, '0, 1'b0);
        add_entry(OP_EXT, 12'h000, 32'h2, '0, 1'b0); // external routing
        add_entry(OP_RD, IrqPend, '0, 32'h8, 1'b0);
        add_mask_case(4'b1000, 4'b0000);
        add_mask_case(4'b0000, 4'b1000);
        add_mask_case(4'b0111, 4'b1111);
        r0 = rand_bits(4);
        r1 = rand_bits(4);
        add_mask_case(r0[3:0], r1[3:0]);
        add_entry(OP_EXT, 12'h000, 32'h0, '0, 1'b0);
        add_entry(OP_IRQ, 12'h000, '0, '0, 1'b0);
    endfunction

    // --------------------
    // APB master
    // --------------------
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int   waited;
        logic done;
        logic early;
        @(negedge clk_i);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_i);
        apb_req.penable = 1'b1;
        early  = apb_rsp.pready;  // first access cycle
        waited = 0;
        done   = 1'b0;
        while (!done && waited < 8) begin
            @(negedge clk_i);
            waited++;
            done = apb_rsp.pready;
        end
        rdata   = apb_rsp.prdata;
        err     = apb_rsp.pslverr;
        apb_req = '0;
        if (!done) begin
            $display("no pready within 8 cycles for access to 0x%h at %0t", addr, $time);
            errors++;
        end else if (early || waited != 1) begin
            $display("pready for access to 0x%h at %0t not in the second access cycle",
                     addr, $time);
            errors++;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("ERR t=%0t %s exp=0x%h got=0x%h", $time, name, exp, got);
        errors++;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] rdata;
        logic        err;
        int          errors_before;
        int          tries;
        reset_i      = 1'b1;
        apb_req      = '0;
        irq_ext      = '0;
        errors       = 0;
        failed_tests = 0;
        table_built  = 1'b0;
        lfsr_q       = 32'h96f6;
        build_table();
        watchdog_cycles = tbl.size() * 3 + 400;
        table_built     = 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        foreach (tbl[i]) begin
            e             = tbl[i];
            errors_before = errors;
            case (e.op)
                OP_WR: begin
                    apb_transfer(1'b1, e.addr, e.wdata, rdata, err);
                    if (err !== e.exp_err)
                        report_mismatch("pslverr", {31'h0, e.exp_err}, {31'h0, err});
                end
                OP_RD: begin
                    apb_transfer(1'b0, e.addr, '0, rdata, err);
                    if (rdata !== e.exp) report_mismatch("prdata", e.exp, rdata);
                    if (err !== e.exp_err)
                        report_mismatch("pslverr", {31'h0, e.exp_err}, {31'h0, err});
                end
                OP_POLL: begin
                    tries = 0;
                    rdata = '0;
                    while (rdata !== e.exp && tries < PollTries) begin
                        apb_transfer(1'b0, e.addr, '0, rdata, err);
                        tries++;
                    end
                    if (rdata !== e.exp) begin
                        $display("register 0x%h never read 0x%h in %0d reads",
                                 e.addr, e.exp, tries);
                        errors++;
                    end
                end
                OP_IDLE: repeat (e.wdata) @(negedge clk_i);
                OP_EXT: begin
                    @(negedge clk_i);
                    irq_ext = e.wdata[1:0];
                end
                default: begin
                    repeat (2) @(negedge clk_i);  // registered router output
                    if (irq !== e.exp[1:0]) report_mismatch("irq_o", e.exp, {30'h0, irq});
                end
            endcase
            if (errors != errors_before) failed_tests++;
            $display("test %0d %s 0x%h %s", i, op_name(e.op), e.addr,
                     (errors == errors_before) ? "ok" : "failed");
        end
        $display("tests=%0d failed=%0d errors=%0d", tbl.size(), failed_tests, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_built === 1'b1);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/periph_map_pkg.sv
hdl/periph_bus_pkg.sv
hdl/apb_access_fsm.sv
hdl/periph_timer.sv
hdl/irq_router.sv
hdl/periph_top.sv
dv/tb_periph_top.sv

// File: run.sh
#!/bin/sh
# Build and run the periph_top testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_periph_top \
    --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
